// ==== hw/cache_pkg.sv ====
// cache package: request opcodes, controller states and default cache geometry
package cache_pkg;

	// request opcodes carried on the request channel
	typedef enum logic [1:0] {
		OP_READ       = 2'd0,
		OP_WRITE      = 2'd1,
		OP_INVALIDATE = 2'd2
	} cache_op_t;

	// request controller states
	typedef enum logic {
		ST_IDLE = 1'b0,
		ST_RESP = 1'b1
	} ctrl_state_t;

	// default geometry, 8 sets of 4 ways
	localparam int DEF_NUM_SETS  = 8;
	localparam int DEF_NUM_WAYS  = 4;
	localparam int DEF_TAG_BITS  = 8;
	localparam int DEF_DATA_BITS = 64;

endpackage

// ==== hw/tag_cam.sv ====
// tag CAM: matches one search tag against every valid way of a set
`timescale 1ns/1ps

module tag_cam #(
	parameter int NUM_WAYS = 4,
	parameter int TAG_BITS = 8
) (
	input  logic [TAG_BITS-1:0]                search_tag,
	input  logic [NUM_WAYS-1:0][TAG_BITS-1:0]  way_tags,
	input  logic [NUM_WAYS-1:0]                way_valid,
	output logic [NUM_WAYS-1:0]                hits
);

	// one comparator per way
	always_comb begin
		for (int i = 0; i < NUM_WAYS; i++) begin
			// stale tags of invalid ways never match
			hits[i] = way_valid[i] && (way_tags[i] == search_tag);
		end
	end

endmodule

// ==== hw/way_alloc.sv ====
// way allocator: lowest free way first, else the set's round-robin victim
`timescale 1ns/1ps

module way_alloc #(
	parameter int NUM_SETS = 8,
	parameter int NUM_WAYS = 4
) (
	input  logic                        clock,
	input  logic                        reset,
	input  logic [$clog2(NUM_SETS)-1:0] set_idx,
	input  logic [NUM_WAYS-1:0]         way_valid,
	input  logic                        evict,
	output logic [NUM_WAYS-1:0]         grant
);

	localparam int WAY_BITS = $clog2(NUM_WAYS);

	// one victim pointer per set
	logic [WAY_BITS-1:0] victim_ptr [NUM_SETS];
	logic                free_found;

	// priority select over the invalid ways
	always_comb begin
		grant = '0;
		free_found = 1'b0;
		for (int i = 0; i < NUM_WAYS; i++) begin
			if (!way_valid[i] && !free_found) begin
				grant[i] = 1'b1;
				free_found = 1'b1;
			end
		end
		// set is full, fall back to the victim
		if (!free_found) begin
			grant[victim_ptr[set_idx]] = 1'b1;
		end
	end

	// pointer moves only when a full set is evicted
	always_ff @(posedge clock) begin
		if (reset) begin
			for (int s = 0; s < NUM_SETS; s++) begin
				victim_ptr[s] <= '0;
			end
		end else if (evict) begin
			if (victim_ptr[set_idx] == WAY_BITS'(NUM_WAYS - 1)) begin
				victim_ptr[set_idx] <= '0;
			end else begin
				victim_ptr[set_idx] <= victim_ptr[set_idx] + 1'b1;
			end
		end
	end

endmodule

// ==== hw/cache_mem.sv ====
// cache storage: tag, valid and data arrays with combinational lookup and commit update
`timescale 1ns/1ps

module cache_mem import cache_pkg::*; #(
	parameter int NUM_SETS  = 8,
	parameter int NUM_WAYS  = 4,
	parameter int TAG_BITS  = 8,
	parameter int DATA_BITS = 64
) (
	input  logic                        clock,
	input  logic                        reset,
	input  cache_op_t                   lookup_op,
	input  logic [$clog2(NUM_SETS)-1:0] lookup_idx,
	input  logic [TAG_BITS-1:0]         lookup_tag,
	input  logic [DATA_BITS-1:0]        lookup_data,
	input  logic                        commit,
	output logic                        hit,
	output logic [DATA_BITS-1:0]        rd_data
);

	localparam int WAY_BITS = $clog2(NUM_WAYS);

	// storage
	logic [NUM_WAYS-1:0][TAG_BITS-1:0] tag_arr   [NUM_SETS];
	logic [NUM_WAYS-1:0]               valid_arr [NUM_SETS];
	logic [DATA_BITS-1:0]              data_arr  [NUM_SETS][NUM_WAYS];

	logic [NUM_WAYS-1:0][TAG_BITS-1:0] set_tags;
	logic [NUM_WAYS-1:0]               set_valid;
	logic [NUM_WAYS-1:0]               hits;
	logic [NUM_WAYS-1:0]               grant;
	logic [NUM_WAYS-1:0]               sel_vec;
	logic [WAY_BITS-1:0]               way_idx;
	logic                              any_hit;
	logic                              set_full;
	logic                              write_miss;
	logic                              evict;

	assign set_tags   = tag_arr[lookup_idx];
	assign set_valid  = valid_arr[lookup_idx];
	assign any_hit    = |hits;
	assign set_full   = &set_valid;
	assign write_miss = (lookup_op == OP_WRITE) && !any_hit;
	assign evict      = commit && write_miss && set_full;

	tag_cam #(
		.NUM_WAYS (NUM_WAYS),
		.TAG_BITS (TAG_BITS)
	) u_tag_cam (
		.search_tag (lookup_tag),
		.way_tags   (set_tags),
		.way_valid  (set_valid),
		.hits       (hits)
	);

	way_alloc #(
		.NUM_SETS (NUM_SETS),
		.NUM_WAYS (NUM_WAYS)
	) u_way_alloc (
		.clock     (clock),
		.reset     (reset),
		.set_idx   (lookup_idx),
		.way_valid (set_valid),
		.evict     (evict),
		.grant     (grant)
	);

	// a write miss takes the allocated way, everything else the matching one
	assign sel_vec = write_miss ? grant : hits;

	always_comb begin
		way_idx = '0;
		for (int i = 0; i < NUM_WAYS; i++) begin
			if (sel_vec[i]) begin
				way_idx = WAY_BITS'(i);
			end
		end
	end

	assign hit     = any_hit;
	assign rd_data = any_hit ? data_arr[lookup_idx][way_idx] : '0;

	// tags and valid bits
	always_ff @(posedge clock) begin
		if (reset) begin
			for (int s = 0; s < NUM_SETS; s++) begin
				tag_arr[s]   <= '0;
				valid_arr[s] <= '0;
			end
		end else if (commit) begin
			if (lookup_op == OP_WRITE) begin
				tag_arr[lookup_idx][way_idx]   <= lookup_tag;
				valid_arr[lookup_idx][way_idx] <= 1'b1;
			end else if (lookup_op == OP_INVALIDATE && any_hit) begin
				valid_arr[lookup_idx][way_idx] <= 1'b0;
			end
		end
	end

	// line data
	always_ff @(posedge clock) begin
		if (commit && lookup_op == OP_WRITE) begin
			data_arr[lookup_idx][way_idx] <= lookup_data;
		end
	end

	// a tag lives in at most one way of its set
	a_hits_onehot0: assert property (@(posedge clock) disable iff (reset)
		$onehot0(hits));

	// allocator must always find a way for a write miss
	a_write_miss_grant: assert property (@(posedge clock) disable iff (reset)
		commit && write_miss |-> $onehot(grant));

endmodule

// ==== hw/cache_ctrl.sv ====
// request controller: accepts one request, registers its response and holds it until taken
`timescale 1ns/1ps

module cache_ctrl import cache_pkg::*; #(
	parameter int NUM_SETS  = 8,
	parameter int TAG_BITS  = 8,
	parameter int DATA_BITS = 64
) (
	input  logic                        clock,
	input  logic                        reset,
	// request channel
	input  logic                        req_valid,
	input  cache_op_t                   req_op,
	input  logic [$clog2(NUM_SETS)-1:0] req_idx,
	input  logic [TAG_BITS-1:0]         req_tag,
	input  logic [DATA_BITS-1:0]        req_data,
	output logic                        req_ready,
	// response channel
	output logic                        resp_valid,
	output logic                        resp_hit,
	output logic [DATA_BITS-1:0]        resp_data,
	input  logic                        resp_ready,
	// cache storage side
	output cache_op_t                   lookup_op,
	output logic [$clog2(NUM_SETS)-1:0] lookup_idx,
	output logic [TAG_BITS-1:0]         lookup_tag,
	output logic [DATA_BITS-1:0]        lookup_data,
	output logic                        commit,
	input  logic                        hit,
	input  logic [DATA_BITS-1:0]        rd_data
);

	ctrl_state_t state;

	// lookup runs straight off the request inputs
	assign lookup_op   = req_op;
	assign lookup_idx  = req_idx;
	assign lookup_tag  = req_tag;
	assign lookup_data = req_data;

	assign req_ready  = (state == ST_IDLE);
	assign resp_valid = (state == ST_RESP);
	assign commit     = req_valid && req_ready;

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= ST_IDLE;
		end else begin
			case (state)
				ST_IDLE: if (req_valid) state <= ST_RESP;
				ST_RESP: if (resp_ready) state <= ST_IDLE;
				default: state <= ST_IDLE;
			endcase
		end
	end

	// response payload, captured on the accept edge
	always_ff @(posedge clock) begin
		if (commit) begin
			resp_hit  <= hit;
			resp_data <= rd_data;
		end
	end

	// response is held steady under back-pressure
	a_resp_hold: assert property (@(posedge clock) disable iff (reset)
		resp_valid && !resp_ready |=> resp_valid && $stable(resp_hit) && $stable(resp_data));

endmodule

// ==== hw/dcache_top.sv ====
// data cache top: request controller in front of the set-associative storage
`timescale 1ns/1ps

module dcache_top import cache_pkg::*; #(
	parameter int NUM_SETS  = DEF_NUM_SETS,
	parameter int NUM_WAYS  = DEF_NUM_WAYS,
	parameter int TAG_BITS  = DEF_TAG_BITS,
	parameter int DATA_BITS = DEF_DATA_BITS
) (
	input  logic                        clock,
	input  logic                        reset,
	input  logic                        req_valid,
	input  cache_op_t                   req_op,
	input  logic [$clog2(NUM_SETS)-1:0] req_idx,
	input  logic [TAG_BITS-1:0]         req_tag,
	input  logic [DATA_BITS-1:0]        req_data,
	output logic                        req_ready,
	output logic                        resp_valid,
	output logic                        resp_hit,
	output logic [DATA_BITS-1:0]        resp_data,
	input  logic                        resp_ready
);

	cache_op_t                   lookup_op;
	logic [$clog2(NUM_SETS)-1:0] lookup_idx;
	logic [TAG_BITS-1:0]         lookup_tag;
	logic [DATA_BITS-1:0]        lookup_data;
	logic                        commit;
	logic                        hit;
	logic [DATA_BITS-1:0]        rd_data;

	cache_ctrl #(
		.NUM_SETS  (NUM_SETS),
		.TAG_BITS  (TAG_BITS),
		.DATA_BITS (DATA_BITS)
	) u_ctrl (
		.clock       (clock),
		.reset       (reset),
		.req_valid   (req_valid),
		.req_op      (req_op),
		.req_idx     (req_idx),
		.req_tag     (req_tag),
		.req_data    (req_data),
		.req_ready   (req_ready),
		.resp_valid  (resp_valid),
		.resp_hit    (resp_hit),
		.resp_data   (resp_data),
		.resp_ready  (resp_ready),
		.lookup_op   (lookup_op),
		.lookup_idx  (lookup_idx),
		.lookup_tag  (lookup_tag),
		.lookup_data (lookup_data),
		.commit      (commit),
		.hit         (hit),
		.rd_data     (rd_data)
	);

	cache_mem #(
		.NUM_SETS  (NUM_SETS),
		.NUM_WAYS  (NUM_WAYS),
		.TAG_BITS  (TAG_BITS),
		.DATA_BITS (DATA_BITS)
	) u_mem (
		.clock       (clock),
		.reset       (reset),
		.lookup_op   (lookup_op),
		.lookup_idx  (lookup_idx),
		.lookup_tag  (lookup_tag),
		.lookup_data (lookup_data),
		.commit      (commit),
		.hit         (hit),
		.rd_data     (rd_data)
	);

endmodule

// ==== testbench/dcache_tb.sv ====
// data cache testbench: directed tests checked against a reference model of the cache
`timescale 1ns/1ps

module dcache_tb import cache_pkg::*; ();

	localparam int NUM_SETS   = DEF_NUM_SETS;
	localparam int NUM_WAYS   = DEF_NUM_WAYS;
	localparam int TAG_BITS   = DEF_TAG_BITS;
	localparam int DATA_BITS  = DEF_DATA_BITS;
	localparam int IDX_BITS   = $clog2(NUM_SETS);
	localparam int MAX_CYCLES = 3000;

	logic                 clock;
	logic                 reset;
	logic                 req_valid;
	cache_op_t            req_op;
	logic [IDX_BITS-1:0]  req_idx;
	logic [TAG_BITS-1:0]  req_tag;
	logic [DATA_BITS-1:0] req_data;
	logic                 req_ready;
	logic                 resp_valid;
	logic                 resp_hit;
	logic [DATA_BITS-1:0] resp_data;
	logic                 resp_ready;

	// reference model state
	logic [TAG_BITS-1:0]  m_tag   [NUM_SETS][NUM_WAYS];
	logic                 m_valid [NUM_SETS][NUM_WAYS];
	logic [DATA_BITS-1:0] m_data  [NUM_SETS][NUM_WAYS];
	int                   m_ptr   [NUM_SETS];

	logic [31:0]          seed = 32'ha59c_f76e;
	logic [TAG_BITS-1:0]  fill_base;
	string                cur_test;
	int                   errors = 0;
	int                   errors_at_start;
	int                   tests_run = 0;
	int                   tests_failed = 0;
	int                   cycles = 0;

	dcache_top #(
		.NUM_SETS  (NUM_SETS),
		.NUM_WAYS  (NUM_WAYS),
		.TAG_BITS  (TAG_BITS),
		.DATA_BITS (DATA_BITS)
	) dut (
		.clock      (clock),
		.reset      (reset),
		.req_valid  (req_valid),
		.req_op     (req_op),
		.req_idx    (req_idx),
		.req_tag    (req_tag),
		.req_data   (req_data),
		.req_ready  (req_ready),
		.resp_valid (resp_valid),
		.resp_hit   (resp_hit),
		.resp_data  (resp_data),
		.resp_ready (resp_ready)
	);

	always #5 clock = ~clock;

	// run limit
	always @(posedge clock) begin
		cycles++;
		if (cycles >= MAX_CYCLES) begin
			$display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
			$display("sim failed");
			$finish;
		end
	end

	function automatic logic [31:0] lcg_next();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed;
	endfunction

	function automatic logic [DATA_BITS-1:0] rand_data();
		logic [31:0] upper;
		upper = lcg_next();
		return {upper, lcg_next()};
	endfunction

	task automatic check_hit(input logic exp, input logic act);
		if (act !== exp) begin
			$display("CHECK FAILED %s hit: expected %0b, actual %0b", cur_test, exp, act);
			errors++;
		end
	endtask

	task automatic check_data(input logic [DATA_BITS-1:0] exp, input logic [DATA_BITS-1:0] act);
		if (act !== exp) begin
			$display("CHECK FAILED %s data: expected %h, actual %h", cur_test, exp, act);
			errors++;
		end
	endtask

	// predicts the response, then applies hit, fill, round-robin evict and invalidate rules
	task automatic model_access(input cache_op_t op, input int idx, input logic [TAG_BITS-1:0] tag,
		input logic [DATA_BITS-1:0] data, output logic exp_hit, output logic [DATA_BITS-1:0] exp_data);
		int way;
		way = -1;
		for (int w = 0; w < NUM_WAYS; w++) begin
			if (m_valid[idx][w] && m_tag[idx][w] == tag) way = w;
		end
		exp_hit = (way >= 0);
		exp_data = '0;
		if (exp_hit) exp_data = m_data[idx][way];
		if (op == OP_WRITE) begin
			// lowest free way, scanned from the top down
			for (int w = NUM_WAYS - 1; w >= 0 && !exp_hit; w--) begin
				if (!m_valid[idx][w]) way = w;
			end
			if (way < 0) begin
				way = m_ptr[idx];
				m_ptr[idx] = (m_ptr[idx] + 1) % NUM_WAYS;
			end
			m_tag[idx][way] = tag;
			m_valid[idx][way] = 1'b1;
			m_data[idx][way] = data;
		end else if (op == OP_INVALIDATE && exp_hit) begin
			m_valid[idx][way] = 1'b0;
		end
	endtask

	// drives one request and returns on the falling edge after acceptance
	task automatic send_req(input cache_op_t op, input int idx, input logic [TAG_BITS-1:0] tag,
		input logic [DATA_BITS-1:0] data);
		@(negedge clock);
		req_valid = 1'b1;
		req_op = op;
		req_idx = IDX_BITS'(idx);
		req_tag = tag;
		req_data = data;
		while (!req_ready) @(negedge clock);
		@(posedge clock);
		@(negedge clock);
		req_valid = 1'b0;
	endtask

	// response is due one cycle after acceptance, optionally held with resp_ready low
	task automatic recv_resp(input int hold, output logic hit, output logic [DATA_BITS-1:0] data);
		if (!resp_valid || req_ready) begin
			$display("ERROR in %s: no response one cycle after the request was accepted", cur_test);
			errors++;
		end
		hit = resp_hit;
		data = resp_data;
		repeat (hold) begin
			@(negedge clock);
			if (!resp_valid || req_ready) begin
				$display("ERROR in %s: response dropped or request taken while held", cur_test);
				errors++;
			end
			check_hit(hit, resp_hit);
			check_data(data, resp_data);
		end
		resp_ready = 1'b1;
		@(posedge clock);
		@(negedge clock);
		resp_ready = 1'b0;
	endtask

	task automatic do_op(input cache_op_t op, input int idx, input logic [TAG_BITS-1:0] tag,
		input logic [DATA_BITS-1:0] data, input int hold);
		logic                 exp_hit;
		logic                 act_hit;
		logic [DATA_BITS-1:0] exp_data;
		logic [DATA_BITS-1:0] act_data;
		model_access(op, idx, tag, data, exp_hit, exp_data);
		send_req(op, idx, tag, data);
		recv_resp(hold, act_hit, act_data);
		check_hit(exp_hit, act_hit);
		check_data(exp_data, act_data);
	endtask

	task automatic read_tags(input int idx, input logic [TAG_BITS-1:0] base, input int count);
		for (int k = 0; k < count; k++) begin
			do_op(OP_READ, idx, base + TAG_BITS'(k), '0, 0);
		end
	endtask

	task automatic begin_test(input string name);
		cur_test = name;
		errors_at_start = errors;
		tests_run++;
	endtask

	task automatic end_test();
		if (errors == errors_at_start) begin
			$display("test %s: ok", cur_test);
		end else begin
			tests_failed++;
			$display("test %s: %0d errors", cur_test, errors - errors_at_start);
		end
	endtask

	task automatic test_reset_reads();
		begin_test("reset_reads");
		for (int s = 0; s < NUM_SETS; s++) begin
			do_op(OP_READ, s, TAG_BITS'(lcg_next()), '0, 0);
		end
		end_test();
	endtask

	task automatic test_write_read();
		logic [TAG_BITS-1:0] tag;
		tag = TAG_BITS'(lcg_next());
		begin_test("write_read");
		do_op(OP_WRITE, 1, tag, rand_data(), 0);
		do_op(OP_READ, 1, tag, '0, 0);
		// same tag again replaces the line
		do_op(OP_WRITE, 1, tag, rand_data(), 0);
		do_op(OP_READ, 1, tag, '0, 0);
		end_test();
	endtask

	task automatic test_fill_set();
		fill_base = TAG_BITS'(lcg_next());
		begin_test("fill_set");
		for (int k = 0; k < NUM_WAYS; k++) begin
			do_op(OP_WRITE, 3, fill_base + TAG_BITS'(k), rand_data(), 0);
		end
		read_tags(3, fill_base, NUM_WAYS);
		// neighbouring sets stay empty
		read_tags(2, fill_base, NUM_WAYS);
		read_tags(4, fill_base, NUM_WAYS);
		end_test();
	endtask

	task automatic test_evict();
		begin_test("evict");
		do_op(OP_WRITE, 3, fill_base + TAG_BITS'(NUM_WAYS), rand_data(), 0);
		do_op(OP_WRITE, 3, fill_base + TAG_BITS'(NUM_WAYS + 1), rand_data(), 0);
		read_tags(3, fill_base, NUM_WAYS + 2);
		end_test();
	endtask

	task automatic test_invalidate();
		begin_test("invalidate");
		do_op(OP_INVALIDATE, 3, fill_base + TAG_BITS'(NUM_WAYS), '0, 0);
		do_op(OP_READ, 3, fill_base + TAG_BITS'(NUM_WAYS), '0, 0);
		do_op(OP_INVALIDATE, 3, fill_base + TAG_BITS'(NUM_WAYS + 5), '0, 0);
		// first write refills the hole, the second one evicts
		do_op(OP_WRITE, 3, fill_base + TAG_BITS'(NUM_WAYS + 2), rand_data(), 0);
		do_op(OP_WRITE, 3, fill_base + TAG_BITS'(NUM_WAYS + 3), rand_data(), 0);
		read_tags(3, fill_base, NUM_WAYS + 4);
		end_test();
	endtask

	task automatic test_backpressure();
		logic [TAG_BITS-1:0] tag;
		tag = TAG_BITS'(lcg_next());
		begin_test("backpressure");
		do_op(OP_WRITE, 5, tag, rand_data(), 4);
		do_op(OP_READ, 5, tag, '0, 6);
		do_op(OP_INVALIDATE, 5, tag, '0, 3);
		do_op(OP_READ, 5, tag, '0, 2);
		end_test();
	endtask

	initial begin
		clock = 1'b0;
		reset = 1'b1;
		req_valid = 1'b0;
		req_op = OP_READ;
		req_idx = '0;
		req_tag = '0;
		req_data = '0;
		resp_ready = 1'b0;
		for (int s = 0; s < NUM_SETS; s++) begin
			m_ptr[s] = 0;
			for (int w = 0; w < NUM_WAYS; w++) begin
				m_valid[s][w] = 1'b0;
			end
		end
		repeat (8) @(posedge clock);
		@(negedge clock);
		reset = 1'b0;
		test_reset_reads();
		test_write_read();
		test_fill_set();
		test_evict();
		test_invalidate();
		test_backpressure();
		$display("summary: %0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

endmodule

// ==== sim.f ====
hw/cache_pkg.sv
hw/tag_cam.sv
hw/way_alloc.sv
hw/cache_mem.sv
hw/cache_ctrl.sv
hw/dcache_top.sv
testbench/dcache_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the data cache simulation with Verilator, run it and check the log
verilator --binary --timing --assert -Wno-fatal --top-module dcache_tb \
	-f sim.f -o dcache_sim > build.log 2>&1 || { cat build.log; echo "build error"; exit 1; }
./obj_dir/dcache_sim > sim.log 2>&1
cat sim.log
grep -qx "sim passed" sim.log && exit 0 || exit 1
